// File: rtl/decode_consts.svh
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// major opcodes, instr[6:0]
`define OPCODE_LOAD          7'b0000011
`define OPCODE_STORE         7'b0100011
`define OPCODE_R_TYPE        7'b0110011
`define OPCODE_I_TYPE        7'b0010011
`define OPCODE_B_TYPE        7'b1100011
`define OPCODE_JAL           7'b1101111
`define OPCODE_JALR          7'b1100111
`define OPCODE_LUI           7'b0110111
`define OPCODE_AUIPC         7'b0010111
`define OPCODE_SYSTEM        7'b1110011

`define FUNCT3_LB            3'b000
`define FUNCT3_LH            3'b001
`define FUNCT3_LW            3'b010
`define FUNCT3_LBU           3'b100
`define FUNCT3_LHU           3'b101
`define FUNCT3_SB            3'b000
`define FUNCT3_SH            3'b001
`define FUNCT3_SW            3'b010
`define FUNCT3_BEQ           3'b000
`define FUNCT3_BNE           3'b001
`define FUNCT3_BLT           3'b100
`define FUNCT3_BGE           3'b101
`define FUNCT3_BLTU          3'b110
`define FUNCT3_BGEU          3'b111
`define FUNCT3_ADD           3'b000 // also sub, addi
`define FUNCT3_SLL           3'b001
`define FUNCT3_SLT           3'b010
`define FUNCT3_SLTU          3'b011
`define FUNCT3_XOR           3'b100
`define FUNCT3_SR            3'b101 // srl / sra, bit 30 picks
`define FUNCT3_OR            3'b110
`define FUNCT3_AND           3'b111
`define FUNCT3_ECALL_EBREAK  3'b000
`define FUNCT3_CSRRW         3'b001
`define FUNCT3_CSRRS         3'b010
`define FUNCT3_CSRRC         3'b011
`define FUNCT3_CSRRWI        3'b101
`define FUNCT3_CSRRSI        3'b110
`define FUNCT3_CSRRCI        3'b111

`define FUNCT7_BASE          7'h00
`define FUNCT7_ALT           7'h20
`define FUNCT12_ECALL        12'h000
`define FUNCT12_EBREAK       12'h001

// mcause codes for synchronous exceptions
`define TRAP_ILLEGAL_INSTR   31'd2
`define TRAP_BREAKPOINT      31'd3
`define TRAP_ECALL_M         31'd11

`endif

// File: rtl/decode_pkg.sv
`default_nettype none

package decode_pkg;

  typedef enum logic [3:0] {
    MEM_NONE, MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU, MEM_SB, MEM_SH, MEM_SW
  } mem_op_t;

  typedef enum logic [1:0] {CF_NONE, CF_BRANCH, CF_JUMP, CF_JALR} cf_op_t;

  typedef enum logic [1:0] {CSR_NONE, CSR_WRITE, CSR_SET, CSR_CLEAR} csr_op_t;

  typedef enum logic [2:0] {
    IMM_I_ALU, IMM_I_SHIFT, IMM_S, IMM_B, IMM_U, IMM_J, IMM_CSR
  } imm_ext_op_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_LT, ALU_LTU, ALU_XOR, ALU_SRL,
    ALU_SRA, ALU_OR, ALU_AND, ALU_NE, ALU_GE, ALU_GEU
  } alu_ctrl_t;

  typedef enum logic [1:0] {A_SEL_REG, A_SEL_PC, A_SEL_ZERO} alu_a_sel_t;
  typedef enum logic {B_SEL_REG, B_SEL_IMM} alu_b_sel_t;
  typedef enum logic [1:0] {RES_ALU, RES_DMEM, RES_NEXT_PC, RES_CSR} result_sel_t;

  // decoder outputs, all-zero is a harmless nop
  typedef struct packed {
    logic        rd_valid;
    logic        rs1_valid;
    logic        rs2_valid;
    mem_op_t     mem_op;
    cf_op_t      cf_op;
    csr_op_t     csr_op;
    alu_ctrl_t   alu_ctrl;
    imm_ext_op_t imm_ext_op;
    alu_a_sel_t  alu_a_sel;
    alu_b_sel_t  alu_b_sel;
    result_sel_t result_sel;
    logic        csr_mask_imm; // csr mask from uimm, not rs1
    logic        trap_valid;
    logic [30:0] trap_mcause;
  } ctrl_t;

  typedef struct packed {
    logic        valid;
    ctrl_t       ctrl;
    logic [31:0] pc;
    logic [31:0] imm;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [4:0]  rd_addr;
  } id_ex_t;

  typedef struct packed {
    logic        en;
    logic [4:0]  addr;
    logic [31:0] data;
  } wb_t;

endpackage

`default_nettype wire

// File: rtl/decoder.sv
`timescale 1ns/100ps
`default_nettype none
`include "decode_consts.svh"

module decoder (
  input  logic [31:0]       instr,
  output decode_pkg::ctrl_t ctrl
);
  import decode_pkg::*;

  typedef enum logic [1:0] {AOP_ADD, AOP_BRANCH, AOP_ARITH} alu_op_t;

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [11:0] funct12;
  logic [4:0]  rs1;
  logic [4:0]  rd;
  logic        alt;
  logic        is_rtype;
  logic        is_shift_funct3;
  logic        is_alt_funct3;
  logic        bad_rtype;
  logic        bad_ishift;
  ctrl_t       dec;
  alu_op_t     alu_op;
  alu_ctrl_t   alu_ctrl;

  assign opcode  = instr[6:0];
  assign funct3  = instr[14:12];
  assign funct7  = instr[31:25];
  assign funct12 = instr[31:20];
  assign rs1     = instr[19:15];
  assign rd      = instr[11:7];
  assign alt     = instr[30]; // sub / sra select

  assign is_rtype        = (opcode == `OPCODE_R_TYPE);
  assign is_shift_funct3 = (funct3 == `FUNCT3_SLL) || (funct3 == `FUNCT3_SR);
  assign is_alt_funct3   = (funct3 == `FUNCT3_ADD) || (funct3 == `FUNCT3_SR);

  // only sub and sra may carry funct7 0x20
  assign bad_rtype  = (funct7 != `FUNCT7_BASE) && !((funct7 == `FUNCT7_ALT) && is_alt_funct3);
  assign bad_ishift = is_shift_funct3 && (funct7 != `FUNCT7_BASE)
                      && !((funct3 == `FUNCT3_SR) && (funct7 == `FUNCT7_ALT));

  always_comb begin
    dec = '0;
    dec.trap_mcause = `TRAP_ILLEGAL_INSTR;
    alu_op = AOP_ADD;
    case (opcode)
      `OPCODE_LOAD: begin
        dec.rd_valid   = 1'b1;
        dec.rs1_valid  = 1'b1;
        dec.alu_b_sel  = B_SEL_IMM;
        dec.result_sel = RES_DMEM;
        case (funct3)
          `FUNCT3_LB:  dec.mem_op = MEM_LB;
          `FUNCT3_LH:  dec.mem_op = MEM_LH;
          `FUNCT3_LW:  dec.mem_op = MEM_LW;
          `FUNCT3_LBU: dec.mem_op = MEM_LBU;
          `FUNCT3_LHU: dec.mem_op = MEM_LHU;
          default:     dec.trap_valid = 1'b1;
        endcase
      end
      `OPCODE_STORE: begin
        dec.rs1_valid  = 1'b1;
        dec.rs2_valid  = 1'b1;
        dec.imm_ext_op = IMM_S;
        dec.alu_b_sel  = B_SEL_IMM;
        case (funct3)
          `FUNCT3_SB: dec.mem_op = MEM_SB;
          `FUNCT3_SH: dec.mem_op = MEM_SH;
          `FUNCT3_SW: dec.mem_op = MEM_SW;
          default:    dec.trap_valid = 1'b1;
        endcase
      end
      `OPCODE_R_TYPE: begin
        if (bad_rtype) begin
          dec.trap_valid = 1'b1;
        end else begin
          dec.rd_valid  = 1'b1;
          dec.rs1_valid = 1'b1;
          dec.rs2_valid = 1'b1;
          alu_op        = AOP_ARITH;
        end
      end
      `OPCODE_I_TYPE: begin
        if (bad_ishift) begin
          dec.trap_valid = 1'b1;
        end else begin
          dec.rd_valid   = 1'b1;
          dec.rs1_valid  = 1'b1;
          dec.alu_b_sel  = B_SEL_IMM;
          dec.imm_ext_op = is_shift_funct3 ? IMM_I_SHIFT : IMM_I_ALU;
          alu_op         = AOP_ARITH;
        end
      end
      `OPCODE_B_TYPE: begin
        dec.rs1_valid  = 1'b1;
        dec.rs2_valid  = 1'b1;
        dec.imm_ext_op = IMM_B;
        dec.cf_op      = CF_BRANCH;
        alu_op         = AOP_BRANCH;
      end
      `OPCODE_JAL: begin
        dec.rd_valid   = 1'b1;
        dec.imm_ext_op = IMM_J;
        dec.cf_op      = CF_JUMP;
        dec.result_sel = RES_NEXT_PC;
      end
      `OPCODE_JALR: begin
        dec.rd_valid   = 1'b1;
        dec.rs1_valid  = 1'b1;
        dec.alu_b_sel  = B_SEL_IMM;
        dec.cf_op      = CF_JALR;
        dec.result_sel = RES_NEXT_PC;
      end
      `OPCODE_LUI, `OPCODE_AUIPC: begin
        dec.rd_valid   = 1'b1;
        dec.imm_ext_op = IMM_U;
        dec.alu_a_sel  = (opcode == `OPCODE_LUI) ? A_SEL_ZERO : A_SEL_PC;
        dec.alu_b_sel  = B_SEL_IMM;
      end
      `OPCODE_SYSTEM: begin
        dec.rd_valid   = 1'b1;
        dec.rs1_valid  = 1'b1;
        dec.result_sel = RES_CSR;
        case (funct3)
          `FUNCT3_ECALL_EBREAK: begin
            dec.trap_valid = 1'b1;
            dec.result_sel = RES_ALU;
            if (rs1 == 5'd0 && rd == 5'd0 && funct12 == `FUNCT12_ECALL)
              dec.trap_mcause = `TRAP_ECALL_M;
            else if (rs1 == 5'd0 && rd == 5'd0 && funct12 == `FUNCT12_EBREAK)
              dec.trap_mcause = `TRAP_BREAKPOINT;
          end
          `FUNCT3_CSRRW:  dec.csr_op = CSR_WRITE;
          `FUNCT3_CSRRS:  dec.csr_op = (rs1 == 5'd0) ? CSR_NONE : CSR_SET;
          `FUNCT3_CSRRC:  dec.csr_op = (rs1 == 5'd0) ? CSR_NONE : CSR_CLEAR;
          `FUNCT3_CSRRWI: begin
            dec.csr_op       = CSR_WRITE;
            dec.imm_ext_op   = IMM_CSR;
            dec.csr_mask_imm = 1'b1;
          end
          `FUNCT3_CSRRSI: begin
            dec.csr_op       = (rs1 == 5'd0) ? CSR_NONE : CSR_SET;
            dec.imm_ext_op   = IMM_CSR;
            dec.csr_mask_imm = 1'b1;
          end
          `FUNCT3_CSRRCI: begin
            dec.csr_op       = (rs1 == 5'd0) ? CSR_NONE : CSR_CLEAR;
            dec.imm_ext_op   = IMM_CSR;
            dec.csr_mask_imm = 1'b1;
          end
          default: dec.trap_valid = 1'b1;
        endcase
      end
      default: dec.trap_valid = 1'b1; // unknown opcode
    endcase
  end

  always_comb begin
    alu_ctrl = ALU_ADD; // loads, stores, jumps, lui, auipc
    case (alu_op)
      AOP_BRANCH: begin
        case (funct3)
          `FUNCT3_BEQ:  alu_ctrl = ALU_SUB;
          `FUNCT3_BNE:  alu_ctrl = ALU_NE;
          `FUNCT3_BLT:  alu_ctrl = ALU_LT;
          `FUNCT3_BGE:  alu_ctrl = ALU_GE;
          `FUNCT3_BLTU: alu_ctrl = ALU_LTU;
          `FUNCT3_BGEU: alu_ctrl = ALU_GEU;
          default: ;
        endcase
      end
      AOP_ARITH: begin
        case (funct3)
          `FUNCT3_ADD:  alu_ctrl = (is_rtype && alt) ? ALU_SUB : ALU_ADD; // addi has imm here
          `FUNCT3_SLL:  alu_ctrl = ALU_SLL;
          `FUNCT3_SLT:  alu_ctrl = ALU_LT;
          `FUNCT3_SLTU: alu_ctrl = ALU_LTU;
          `FUNCT3_XOR:  alu_ctrl = ALU_XOR;
          `FUNCT3_SR:   alu_ctrl = alt ? ALU_SRA : ALU_SRL;
          `FUNCT3_OR:   alu_ctrl = ALU_OR;
          `FUNCT3_AND:  alu_ctrl = ALU_AND;
          default: ;
        endcase
      end
      default: ;
    endcase
  end

  always_comb begin
    ctrl = dec;
    ctrl.alu_ctrl = alu_ctrl;
    if (dec.trap_valid)
      ctrl.rd_valid = 1'b0; // trapped instr writes nothing
  end

endmodule

`default_nettype wire

// File: rtl/imm_extender.sv
`timescale 1ns/100ps
`default_nettype none

module imm_extender (
  input  logic [31:0]             instr,
  input  decode_pkg::imm_ext_op_t imm_ext_op,
  output logic [31:0]             imm
);
  import decode_pkg::*;

  logic sign;

  assign sign = instr[31];

  always_comb begin
    case (imm_ext_op)
      IMM_I_ALU:   imm = {{20{sign}}, instr[31:20]};
      IMM_I_SHIFT: imm = {27'd0, instr[24:20]}; // shamt
      IMM_S:       imm = {{20{sign}}, instr[31:25], instr[11:7]};
      IMM_B:       imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
      IMM_U:       imm = {instr[31:12], 12'd0};
      IMM_J:       imm = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
      IMM_CSR:     imm = {27'd0, instr[19:15]}; // uimm sits in rs1 field
      default:     imm = 32'd0;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/register_file.sv
`timescale 1ns/100ps
`default_nettype none

module register_file (
  input  logic            clk,
  input  logic            rst_n,
  input  decode_pkg::wb_t wb,
  input  logic [4:0]      rs1_addr,
  input  logic [4:0]      rs2_addr,
  output logic [31:0]     rs1_data,
  output logic [31:0]     rs2_data
);

  logic [31:0] regs [31:1]; // x0 not stored

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++)
        regs[i] <= 32'd0;
    end else if (wb.en && wb.addr != 5'd0) begin
      regs[wb.addr] <= wb.data;
    end
  end

  // one read port, same-cycle write wins
  function automatic logic [31:0] read_port(input logic [4:0] addr);
    if (addr == 5'd0)
      return 32'd0;
    if (wb.en && wb.addr == addr)
      return wb.data;
    return regs[addr];
  endfunction

  always_comb begin
    rs1_data = read_port(rs1_addr);
    rs2_data = read_port(rs2_addr);
  end

endmodule

`default_nettype wire

// File: rtl/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               instr_valid,
  input  logic [31:0]        instr,
  input  logic [31:0]        pc,
  input  decode_pkg::wb_t    wb,
  output decode_pkg::id_ex_t id_ex
);
  import decode_pkg::*;

  ctrl_t       ctrl;
  logic [31:0] imm;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic [4:0]  rs1_addr;
  logic [4:0]  rs2_addr;
  logic [4:0]  rd_addr;

  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];
  assign rd_addr  = instr[11:7];

  decoder u_decoder (.instr(instr), .ctrl(ctrl));

  imm_extender u_imm_extender (.instr(instr), .imm_ext_op(ctrl.imm_ext_op), .imm(imm));

  register_file u_register_file (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb       (wb),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // no stall, loads every cycle
  always_ff @(posedge clk) begin
    if (!rst_n)
      id_ex <= '0;
    else
      id_ex <= '{valid: instr_valid, ctrl: instr_valid ? ctrl : '0, // bubbles carry a nop
                 pc: pc, imm: imm, rs1_data: rs1_data, rs2_data: rs2_data,
                 rs1_addr: rs1_addr, rs2_addr: rs2_addr, rd_addr: rd_addr};
  end

endmodule

`default_nettype wire

// File: sim/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
  output logic clk
);

  initial clk = 1'b0;

  always #2 clk = ~clk; // 4 ns period

endmodule

`default_nettype wire

// File: sim/tb_decode_stage.sv
`timescale 1ns/100ps
`default_nettype none
`include "decode_consts.svh"

module tb_decode_stage;
  import decode_pkg::*;

  localparam int NUM_CYCLES = 3000;
  localparam int CLK_NS     = 4;

  logic        clk;
  logic        rst_n;
  logic        instr_valid;
  logic [31:0] instr;
  logic [31:0] pc;
  wb_t         wb;
  id_ex_t      id_ex;

  logic [31:0] lcg_state = 32'd19241;
  logic [31:0] shadow [32];
  id_ex_t      exp_q [$];
  int          errors = 0;

  tb_clock u_clock (.clk(clk));

  decode_stage uut (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .pc          (pc),
    .wb          (wb),
    .id_ex       (id_ex)
  );

  // two lcg steps, upper halves only
  function automatic logic [31:0] rand32();
    logic [31:0] a;
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    a = lcg_state;
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {a[31:16], lcg_state[31:16]};
  endfunction

  function automatic logic [31:0] legal_instr();
    logic [31:0] r;
    logic [6:0]  op;
    logic [6:0]  f7;
    logic [4:0]  rs2;
    logic [4:0]  rs1;
    logic [2:0]  f3;
    logic [4:0]  rd;
    {f7, rs2, rs1, f3, rd, op} = rand32();
    r = rand32();
    case (r[3:0])
      4'd0: op = `OPCODE_LOAD;
      4'd1: op = `OPCODE_STORE;
      4'd2: op = `OPCODE_R_TYPE;
      4'd3: op = `OPCODE_I_TYPE;
      4'd4: op = `OPCODE_B_TYPE;
      4'd5: op = `OPCODE_JAL;
      4'd6: op = `OPCODE_JALR;
      4'd7: op = `OPCODE_LUI;
      4'd8: op = `OPCODE_AUIPC;
      default: op = `OPCODE_SYSTEM;
    endcase
    case (op)
      `OPCODE_LOAD: if (f3 == 3'd3 || f3 > 3'd5) f3 = `FUNCT3_LW;
      `OPCODE_STORE: f3 = (f3[1:0] == 2'd3) ? `FUNCT3_SW : {1'b0, f3[1:0]};
      `OPCODE_R_TYPE:
        f7 = (r[7] && (f3 == `FUNCT3_ADD || f3 == `FUNCT3_SR)) ? `FUNCT7_ALT : `FUNCT7_BASE;
      `OPCODE_I_TYPE: begin
        if (f3 == `FUNCT3_SLL)
          f7 = `FUNCT7_BASE;
        else if (f3 == `FUNCT3_SR)
          f7 = r[7] ? `FUNCT7_ALT : `FUNCT7_BASE;
      end
      `OPCODE_B_TYPE: if (f3[2:1] == 2'b01) f3[2] = 1'b1; // no branch at 010/011
      `OPCODE_JALR: f3 = 3'd0;
      `OPCODE_SYSTEM: begin
        if (f3 == 3'd4)
          f3 = `FUNCT3_CSRRW;
        if (f3 == `FUNCT3_ECALL_EBREAK) begin
          {f7, rs2} = r[8] ? `FUNCT12_EBREAK : `FUNCT12_ECALL;
          rs1 = 5'd0;
          rd  = 5'd0;
          case (r[12:11]) // some fail to qualify
            2'd1:    rs1[0] = 1'b1;
            2'd2:    rd[0]  = 1'b1;
            2'd3:    rs2[1] = r[13]; // unknown funct12
            default: ;
          endcase
        end else if (r[10:9] == 2'd0) begin
          rs1 = 5'd0; // csr read only
        end
      end
      default: ;
    endcase
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  task automatic model_ctrl(input logic [31:0] ins, output ctrl_t c);
    logic [6:0] op;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       arith;
    op    = ins[6:0];
    f3    = ins[14:12];
    f7    = ins[31:25];
    arith = 1'b0;
    c = '0;
    c.trap_mcause = `TRAP_ILLEGAL_INSTR;
    case (op)
      `OPCODE_LOAD, `OPCODE_STORE: begin
        c.rs1_valid = 1'b1;
        c.alu_b_sel = B_SEL_IMM;
        if (op == `OPCODE_LOAD) begin
          c.rd_valid   = 1'b1;
          c.result_sel = RES_DMEM;
          case (f3)
            `FUNCT3_LB:  c.mem_op = MEM_LB;
            `FUNCT3_LH:  c.mem_op = MEM_LH;
            `FUNCT3_LW:  c.mem_op = MEM_LW;
            `FUNCT3_LBU: c.mem_op = MEM_LBU;
            `FUNCT3_LHU: c.mem_op = MEM_LHU;
            default:     c.trap_valid = 1'b1;
          endcase
        end else begin
          c.rs2_valid  = 1'b1;
          c.imm_ext_op = IMM_S;
          case (f3)
            `FUNCT3_SB: c.mem_op = MEM_SB;
            `FUNCT3_SH: c.mem_op = MEM_SH;
            `FUNCT3_SW: c.mem_op = MEM_SW;
            default:    c.trap_valid = 1'b1;
          endcase
        end
      end
      `OPCODE_R_TYPE, `OPCODE_I_TYPE: begin
        if (op == `OPCODE_R_TYPE)
          c.trap_valid = f7 != `FUNCT7_BASE &&
                         !(f7 == `FUNCT7_ALT && (f3 == `FUNCT3_ADD || f3 == `FUNCT3_SR));
        else
          c.trap_valid = (f3 == `FUNCT3_SLL && f7 != `FUNCT7_BASE) ||
                         (f3 == `FUNCT3_SR && f7 != `FUNCT7_BASE && f7 != `FUNCT7_ALT);
        if (!c.trap_valid) begin
          arith       = 1'b1;
          c.rd_valid  = 1'b1;
          c.rs1_valid = 1'b1;
          if (op == `OPCODE_R_TYPE) begin
            c.rs2_valid = 1'b1;
          end else begin
            c.alu_b_sel  = B_SEL_IMM;
            c.imm_ext_op = (f3 == `FUNCT3_SLL || f3 == `FUNCT3_SR) ? IMM_I_SHIFT : IMM_I_ALU;
          end
        end
      end
      `OPCODE_B_TYPE: begin
        c.rs1_valid  = 1'b1;
        c.rs2_valid  = 1'b1;
        c.imm_ext_op = IMM_B;
        c.cf_op      = CF_BRANCH;
        case (f3)
          `FUNCT3_BEQ:  c.alu_ctrl = ALU_SUB;
          `FUNCT3_BNE:  c.alu_ctrl = ALU_NE;
          `FUNCT3_BLT:  c.alu_ctrl = ALU_LT;
          `FUNCT3_BGE:  c.alu_ctrl = ALU_GE;
          `FUNCT3_BLTU: c.alu_ctrl = ALU_LTU;
          `FUNCT3_BGEU: c.alu_ctrl = ALU_GEU;
          default:      c.alu_ctrl = ALU_ADD;
        endcase
      end
      `OPCODE_JAL: begin
        c.rd_valid   = 1'b1;
        c.imm_ext_op = IMM_J;
        c.cf_op      = CF_JUMP;
        c.result_sel = RES_NEXT_PC;
      end
      `OPCODE_JALR: begin
        c.rd_valid   = 1'b1;
        c.rs1_valid  = 1'b1;
        c.alu_b_sel  = B_SEL_IMM;
        c.cf_op      = CF_JALR;
        c.result_sel = RES_NEXT_PC;
      end
      `OPCODE_LUI, `OPCODE_AUIPC: begin
        c.rd_valid   = 1'b1;
        c.imm_ext_op = IMM_U;
        c.alu_b_sel  = B_SEL_IMM;
        c.alu_a_sel  = (op == `OPCODE_LUI) ? A_SEL_ZERO : A_SEL_PC;
      end
      `OPCODE_SYSTEM: begin
        c.rd_valid   = 1'b1;
        c.rs1_valid  = 1'b1;
        c.result_sel = RES_CSR;
        if (f3 == `FUNCT3_ECALL_EBREAK) begin
          c.trap_valid = 1'b1;
          c.result_sel = RES_ALU;
          if (ins[19:7] == 13'd0 && ins[31:20] == `FUNCT12_ECALL)
            c.trap_mcause = `TRAP_ECALL_M;
          else if (ins[19:7] == 13'd0 && ins[31:20] == `FUNCT12_EBREAK)
            c.trap_mcause = `TRAP_BREAKPOINT;
        end else if (f3 == 3'd4) begin
          c.trap_valid = 1'b1;
        end else begin
          // f3[2] picks uimm, f3[1:0] picks write/set/clear
          c.csr_mask_imm = f3[2];
          if (f3[2])
            c.imm_ext_op = IMM_CSR;
          if (f3[1:0] == 2'd1)
            c.csr_op = CSR_WRITE;
          else if (ins[19:15] != 5'd0)
            c.csr_op = (f3[1:0] == 2'd2) ? CSR_SET : CSR_CLEAR;
        end
      end
      default: c.trap_valid = 1'b1;
    endcase
    if (arith) begin
      case (f3)
        `FUNCT3_ADD:  c.alu_ctrl = (op == `OPCODE_R_TYPE && ins[30]) ? ALU_SUB : ALU_ADD;
        `FUNCT3_SLL:  c.alu_ctrl = ALU_SLL;
        `FUNCT3_SLT:  c.alu_ctrl = ALU_LT;
        `FUNCT3_SLTU: c.alu_ctrl = ALU_LTU;
        `FUNCT3_XOR:  c.alu_ctrl = ALU_XOR;
        `FUNCT3_SR:   c.alu_ctrl = ins[30] ? ALU_SRA : ALU_SRL;
        `FUNCT3_OR:   c.alu_ctrl = ALU_OR;
        `FUNCT3_AND:  c.alu_ctrl = ALU_AND;
      endcase
    end
    if (c.trap_valid)
      c.rd_valid = 1'b0;
  endtask

  // immediate fields moved to the top, then arithmetic shift down
  function automatic logic [31:0] model_imm(input logic [31:0] ins, input imm_ext_op_t kind);
    case (kind)
      IMM_I_ALU:   return $signed(ins) >>> 20;
      IMM_I_SHIFT: return {27'd0, ins[24:20]};
      IMM_S:       return $signed({ins[31:25], ins[11:7], 20'd0}) >>> 20;
      IMM_B:       return $signed({ins[31], ins[7], ins[30:25], ins[11:8], 20'd0}) >>> 19;
      IMM_U:       return {ins[31:12], 12'd0};
      IMM_J:       return $signed({ins[31], ins[19:12], ins[20], ins[30:21], 12'd0}) >>> 11;
      IMM_CSR:     return {27'd0, ins[19:15]};
      default:     return 32'd0;
    endcase
  endfunction

  function automatic logic [31:0] read_shadow(input logic [4:0] addr);
    if (addr == 5'd0)
      return 32'd0;
    if (wb.en && wb.addr == addr)
      return wb.data; // same-cycle write
    return shadow[addr];
  endfunction

  task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      errors++;
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_record();
    id_ex_t e;
    assert (exp_q.size() != 0) else begin
      errors++;
      $display("no expected record was queued for the output at %0t", $time);
    end
    if (exp_q.size() != 0) begin
      e = exp_q.pop_front();
      check_field("valid", 32'(e.valid), 32'(id_ex.valid));
      check_field("rd_valid", 32'(e.ctrl.rd_valid), 32'(id_ex.ctrl.rd_valid));
      check_field("rs1_valid", 32'(e.ctrl.rs1_valid), 32'(id_ex.ctrl.rs1_valid));
      check_field("rs2_valid", 32'(e.ctrl.rs2_valid), 32'(id_ex.ctrl.rs2_valid));
      check_field("mem_op", 32'(e.ctrl.mem_op), 32'(id_ex.ctrl.mem_op));
      check_field("cf_op", 32'(e.ctrl.cf_op), 32'(id_ex.ctrl.cf_op));
      check_field("csr_op", 32'(e.ctrl.csr_op), 32'(id_ex.ctrl.csr_op));
      check_field("alu_ctrl", 32'(e.ctrl.alu_ctrl), 32'(id_ex.ctrl.alu_ctrl));
      check_field("imm_ext_op", 32'(e.ctrl.imm_ext_op), 32'(id_ex.ctrl.imm_ext_op));
      check_field("alu_a_sel", 32'(e.ctrl.alu_a_sel), 32'(id_ex.ctrl.alu_a_sel));
      check_field("alu_b_sel", 32'(e.ctrl.alu_b_sel), 32'(id_ex.ctrl.alu_b_sel));
      check_field("result_sel", 32'(e.ctrl.result_sel), 32'(id_ex.ctrl.result_sel));
      check_field("csr_mask_imm", 32'(e.ctrl.csr_mask_imm), 32'(id_ex.ctrl.csr_mask_imm));
      check_field("trap_valid", 32'(e.ctrl.trap_valid), 32'(id_ex.ctrl.trap_valid));
      check_field("trap_mcause", 32'(e.ctrl.trap_mcause), 32'(id_ex.ctrl.trap_mcause));
      check_field("pc", e.pc, id_ex.pc);
      check_field("imm", e.imm, id_ex.imm);
      check_field("rs1_data", e.rs1_data, id_ex.rs1_data);
      check_field("rs2_data", e.rs2_data, id_ex.rs2_data);
      check_field("rs1_addr", 32'(e.rs1_addr), 32'(id_ex.rs1_addr));
      check_field("rs2_addr", 32'(e.rs2_addr), 32'(id_ex.rs2_addr));
      check_field("rd_addr", 32'(e.rd_addr), 32'(id_ex.rd_addr));
    end
  endtask

  initial begin : stimulus
    id_ex_t      e;
    ctrl_t       c;
    logic [31:0] r;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = 32'd0;
    pc          = 32'd0;
    wb          = '0;
    for (int i = 0; i < 32; i++)
      shadow[i] = 32'd0;
    exp_q.push_back('0); // first edge is in reset
    for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
      @(posedge clk);
      #1;
      check_record();
      // mirror what the edge just wrote
      if (!rst_n) begin
        for (int i = 0; i < 32; i++)
          shadow[i] = 32'd0;
      end else if (wb.en && wb.addr != 5'd0) begin
        shadow[wb.addr] = wb.data;
      end
      r = rand32();
      rst_n       = (cyc >= 7);
      instr_valid = (r[1:0] != 2'd0);
      instr       = r[2] ? legal_instr() : rand32();
      pc          = rand32() & 32'hffff_fffc;
      wb.en       = r[3];
      wb.data     = rand32();
      if (r[5:4] == 2'd0)
        wb.addr = instr[19:15]; // bypass to rs1
      else if (r[7:6] == 2'd0)
        wb.addr = instr[24:20];
      else
        wb.addr = r[12:8];
      if (!rst_n) begin
        e = '0;
      end else begin
        model_ctrl(instr, c);
        e.valid    = instr_valid;
        e.ctrl     = instr_valid ? c : '0; // bubble reads as nop
        e.pc       = pc;
        e.imm      = model_imm(instr, c.imm_ext_op);
        e.rs1_data = read_shadow(instr[19:15]);
        e.rs2_data = read_shadow(instr[24:20]);
        e.rs1_addr = instr[19:15];
        e.rs2_addr = instr[24:20];
        e.rd_addr  = instr[11:7];
      end
      exp_q.push_back(e);
    end
    @(posedge clk);
    #1;
    check_record();
    $display("decode stage run finished with %0d errors", errors);
    if (errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

  initial begin : watchdog
    #((NUM_CYCLES + 8 + 100) * CLK_NS);
    $display("timeout, the stimulus did not finish in time");
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+rtl
rtl/decode_pkg.sv
rtl/decoder.sv
rtl/imm_extender.sv
rtl/register_file.sv
rtl/decode_stage.sv
sim/tb_clock.sv
sim/tb_decode_stage.sv

// File: Makefile
TOP  := tb_decode_stage
BIN  := obj_dir/V$(TOP)
SRCS := $(filter-out +incdir+%,$(shell cat project.f)) rtl/decode_consts.svh

.PHONY: all run clean

all: run

$(BIN): project.f $(SRCS)
	verilator --binary --timing --assert -f project.f --top-module $(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'Test completed successfully'

clean:
	rm -rf obj_dir
